// ==== design/elink_pkg.sv ====
package elink_pkg;

   //############################
   // field widths of a transaction
   //############################
   localparam int CMD_W      = 4;
   localparam int DATAMODE_W = 2;
   localparam int CTRLMODE_W = 3;
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;

   // frame byte seen on every word inside a packet
   localparam logic [7:0] FRAME_ON = 8'hff;

   // emesh commands, codes not listed here are illegal
   typedef enum logic [CMD_W-1:0] {
      cmd_write       = 4'h0,
      cmd_read        = 4'h1,
      cmd_write_burst = 4'h2
   } emesh_cmd_t;

   // one decoded transaction, 105 bits
   typedef struct packed {
      emesh_cmd_t            cmd;       // command nibble from head byte 0
      logic [DATAMODE_W-1:0] datamode;  // access size
      logic [CTRLMODE_W-1:0] ctrlmode;  // routing / special modes
      logic [ADDR_W-1:0]     dstaddr;   // destination address
      logic [DATA_W-1:0]     data;      // split across head and tail word
      logic [ADDR_W-1:0]     srcaddr;   // return address for reads
   } emesh_packet_t;

   // frame decoder states
   typedef enum logic [1:0] {
      fs_idle,  // waiting for frame to drop
      fs_head,  // gap seen, next frame word is a head
      fs_tail   // head latched, next frame word is a tail
   } frame_state_t;

endpackage

// ==== design/erx_cfg_pkg.sv ====
package erx_cfg_pkg;

   //############################
   // receive queues
   //############################
   localparam int QUEUE_DEPTH = 8;   // entries per queue
   localparam int QUEUE_PTR_W = 3;   // log2 of depth
   localparam int WAIT_LEVEL  = 6;   // fill count that raises link wait

   // credit handshake towards the consumer
   localparam int CREDIT_INIT = 4;   // credits held after reset
   localparam int CREDIT_W    = 3;   // must hold CREDIT_INIT

   //############################
   // input conditioning
   //############################
   localparam int SYNC_STAGES = 2;   // flops in enable and gpio synchronizers

endpackage

// ==== design/erx_io.sv ====
module erx_io
   import erx_cfg_pkg::*;
(
   input  logic        rx_lclk_div4,
   input  logic        rxreset,
   input  logic [7:0]  rx_frame_des,        // frame bits from deserializer
   input  logic [63:0] rx_data_des,         // byte k = bits 8k+7..8k
   input  logic        ecfg_rx_enable,
   input  logic        ecfg_rx_gpio_enable,
   input  logic [1:0]  ecfg_dataout,        // {wr_wait, rd_wait} in gpio mode
   input  logic        wr_wait,             // from write queue
   input  logic        rd_wait,             // from read queue
   output logic [7:0]  rx_frame_par,
   output logic [63:0] rx_data_par,
   output logic [8:0]  ecfg_rx_datain,      // gpio sample {frame bit 0, byte 0}
   output logic        rxo_wr_wait,
   output logic        rxo_rd_wait
);

   logic                   io_reset;     // link reset or rx disabled
   logic [SYNC_STAGES-1:0] rxenb_sync;
   logic [SYNC_STAGES-1:0] rxgpio_sync;
   logic                   rxenb;        // synchronized enable
   logic                   rxgpio;       // synchronized gpio mode
   logic [63:0]            rx_data_reg;
   logic [7:0]             rx_frame_reg;
   logic [8:0]             datain_reg;

   assign io_reset = rxreset | ~ecfg_rx_enable;

   //############################
   // control synchronizers
   //############################
   // a low enable holds the chain cleared, ones shift in once it rises
   always_ff @(posedge rx_lclk_div4 or posedge io_reset)
   begin
      if (io_reset)
         rxenb_sync <= '0;
      else
         rxenb_sync <= {rxenb_sync[SYNC_STAGES-2:0], 1'b1};
   end

   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
         rxgpio_sync <= '0;
      else
         rxgpio_sync <= {rxgpio_sync[SYNC_STAGES-2:0], ecfg_rx_gpio_enable};
   end

   assign rxenb  = rxenb_sync[SYNC_STAGES-1];
   assign rxgpio = rxgpio_sync[SYNC_STAGES-1];

   //############################
   // parallel data path
   //############################
   always_ff @(posedge rx_lclk_div4)
   begin
      rx_data_reg <= rx_data_des;   // stage 1
      rx_data_par <= rx_data_reg;   // stage 2
   end

   // frame is killed while disabled or while pins are used as gpio
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         rx_frame_reg <= '0;
         rx_frame_par <= '0;
      end
      else
      begin
         rx_frame_reg <= rx_frame_des & {8{rxenb & ~rxgpio}};
         rx_frame_par <= rx_frame_reg;
      end
   end

   //############################
   // gpio input sampling
   //############################
   // raw pins, not masked, so software sees them in gpio mode
   always_ff @(posedge rx_lclk_div4)
   begin
      datain_reg     <= {rx_frame_des[0], rx_data_des[7:0]};
      ecfg_rx_datain <= datain_reg;
   end

   // wait pins, combinational
   assign rxo_wr_wait = rxgpio ? ecfg_dataout[1] : wr_wait;
   assign rxo_rd_wait = rxgpio ? ecfg_dataout[0] : rd_wait;

endmodule

// ==== design/erx_protocol.sv ====
module erx_protocol
   import elink_pkg::*;
(
   input  logic          rx_lclk_div4,
   input  logic          rxreset,
   input  logic [7:0]    rx_frame_par,
   input  logic [63:0]   rx_data_par,
   output logic          pkt_valid,     // one cycle per decoded packet
   output emesh_packet_t pkt
);

   frame_state_t state;
   logic         frame_on;     // word is inside a packet
   logic         head_cycle;   // head word on input
   logic         tail_cycle;   // tail word on input
   logic [7:0]   b [8];        // input word split into bytes

   assign frame_on   = (rx_frame_par == FRAME_ON);
   assign head_cycle = (state == fs_head) && frame_on;
   assign tail_cycle = (state == fs_tail) && frame_on;

   always_comb
   begin
      for (int k = 0; k < 8; k++)
         b[k] = rx_data_par[8*k +: 8];
   end

   //############################
   // frame state machine
   //############################
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         state     <= fs_idle;
         pkt_valid <= 1'b0;
      end
      else
      begin
         pkt_valid <= 1'b0;   // default, pulse only
         case (state)
            fs_idle:
            begin
               if (!frame_on)
                  state <= fs_head;   // gap seen, arm for a head
            end
            fs_head:
            begin
               if (frame_on)
                  state <= fs_tail;
            end
            fs_tail:
            begin
               if (frame_on)
               begin
                  pkt_valid <= 1'b1;
                  state     <= fs_idle;   // hold off until frame drops
               end
               else
                  state <= fs_head;   // frame dropped after one word, start over
            end
            default: state <= fs_idle;
         endcase
      end
   end

   //############################
   // field extraction
   //############################
   // payload, qualified by pkt_valid downstream
   always_ff @(posedge rx_lclk_div4)
   begin
      if (head_cycle)
      begin
         pkt.cmd           <= emesh_cmd_t'(b[0][3:0]);   // may be illegal
         pkt.datamode      <= b[0][5:4];
         pkt.ctrlmode      <= b[1][2:0];
         pkt.dstaddr       <= {b[2], b[3], b[4], b[5]};   // msb first
         pkt.data[31:16]   <= {b[6], b[7]};
      end
      if (tail_cycle)
      begin
         pkt.data[15:0] <= {b[0], b[1]};
         pkt.srcaddr    <= {b[2], b[3], b[4], b[5]};   // bytes 6,7 unused
      end
   end

   // decoder must leave a gap after every packet
   a_valid_pulse : assert property (@(posedge rx_lclk_div4) disable iff (rxreset)
      pkt_valid |=> !pkt_valid)
      else $error("pkt_valid high on two consecutive cycles");

endmodule

// ==== design/erx_disty.sv ====
module erx_disty
   import elink_pkg::*;
(
   input  logic          rx_lclk_div4,
   input  logic          rxreset,
   input  logic          pkt_valid,
   input  emesh_packet_t pkt,
   output logic          wr_push,         // to write queue
   output logic          rd_push,         // to read queue
   output emesh_packet_t push_packet,     // shared by both queues
   output logic [7:0]    bad_cmd_count    // saturating
);

   logic wr_sel;
   logic rd_sel;
   logic bad_sel;

   // command decode
   always_comb
   begin
      wr_sel  = 1'b0;
      rd_sel  = 1'b0;
      bad_sel = 1'b0;
      case (pkt.cmd)
         cmd_write,
         cmd_write_burst: wr_sel = pkt_valid;
         cmd_read:        rd_sel = pkt_valid;
         default:         bad_sel = pkt_valid;   // dropped
      endcase
   end

   //############################
   // push and error counter
   //############################
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         wr_push       <= 1'b0;
         rd_push       <= 1'b0;
         bad_cmd_count <= '0;
      end
      else
      begin
         wr_push <= wr_sel;
         rd_push <= rd_sel;
         if (bad_sel && (bad_cmd_count != 8'hff))
            bad_cmd_count <= bad_cmd_count + 8'd1;   // stick at max
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (pkt_valid)
         push_packet <= pkt;
   end

   // a transaction goes to exactly one queue
   a_one_queue : assert property (@(posedge rx_lclk_div4) disable iff (rxreset)
      !(wr_push && rd_push))
      else $error("packet pushed to both queues");

endmodule

// ==== design/erx_fifo.sv ====
module erx_fifo
   import elink_pkg::*, erx_cfg_pkg::*;
(
   input  logic          rx_lclk_div4,
   input  logic          rxreset,
   input  logic          push,
   input  emesh_packet_t push_packet,
   input  logic          credit_return,   // one credit back per pulse
   output logic          queue_wait,      // near full, sender must stop
   output logic          access,          // one cycle per released entry
   output emesh_packet_t packet
);

   emesh_packet_t          mem [QUEUE_DEPTH];
   logic [QUEUE_PTR_W-1:0] wr_ptr;
   logic [QUEUE_PTR_W-1:0] rd_ptr;
   logic [QUEUE_PTR_W:0]   fill;       // 0..QUEUE_DEPTH
   logic [CREDIT_W-1:0]    credit;
   logic                   full;
   logic                   wr_en;
   logic                   pop;

   assign full  = (fill == QUEUE_DEPTH);
   assign wr_en = push && !full;                  // overflow dropped, see assertion
   assign pop   = (fill != '0) && (credit != '0);  // release only against a credit

   assign queue_wait = (fill >= WAIT_LEVEL);

   //############################
   // storage
   //############################
   always_ff @(posedge rx_lclk_div4)
   begin
      if (wr_en)
         mem[wr_ptr] <= push_packet;
      if (pop)
         packet <= mem[rd_ptr];   // valid with access
   end

   //############################
   // pointers, fill and credits
   //############################
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         credit <= CREDIT_W'(CREDIT_INIT);
         access <= 1'b0;
      end
      else
      begin
         access <= pop;
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
         case ({pop, credit_return})
            2'b10:   credit <= credit - 1'b1;   // spent on an access
            2'b01:   credit <= credit + 1'b1;   // returned by consumer
            default: credit <= credit;          // none, or both cancel
         endcase
      end
   end

   // sender ignored queue_wait
   a_no_overflow : assert property (@(posedge rx_lclk_div4) disable iff (rxreset)
      push |-> !full)
      else $error("push into full queue");

   // consumer returned more than it was given
   a_credit_max : assert property (@(posedge rx_lclk_div4) disable iff (rxreset)
      credit <= CREDIT_INIT)
      else $error("credit count above CREDIT_INIT");

endmodule

// ==== design/erx_top.sv ====
module erx_top
   import elink_pkg::*;
(
   input  logic          rx_lclk_div4,
   input  logic          rxreset,
   input  logic [7:0]    rx_frame_des,
   input  logic [63:0]   rx_data_des,
   input  logic          ecfg_rx_enable,
   input  logic          ecfg_rx_gpio_enable,
   input  logic [1:0]    ecfg_dataout,
   input  logic          wr_credit_return,
   input  logic          rd_credit_return,
   output logic          rxo_wr_wait,
   output logic          rxo_rd_wait,
   output logic [8:0]    ecfg_rx_datain,
   output logic          wr_access,
   output emesh_packet_t wr_packet,
   output logic          rd_access,
   output emesh_packet_t rd_packet,
   output logic [7:0]    bad_cmd_count
);

   //############################
   // internal links
   //############################
   logic [7:0]    rx_frame_par;
   logic [63:0]   rx_data_par;
   logic          pkt_valid;
   emesh_packet_t pkt;
   logic          wr_push;
   logic          rd_push;
   emesh_packet_t push_packet;   // fans out to both queues
   logic          wr_wait;
   logic          rd_wait;

   erx_io u_io (
      .rx_lclk_div4        (rx_lclk_div4),
      .rxreset             (rxreset),
      .rx_frame_des        (rx_frame_des),
      .rx_data_des         (rx_data_des),
      .ecfg_rx_enable      (ecfg_rx_enable),
      .ecfg_rx_gpio_enable (ecfg_rx_gpio_enable),
      .ecfg_dataout        (ecfg_dataout),
      .wr_wait             (wr_wait),
      .rd_wait             (rd_wait),
      .rx_frame_par        (rx_frame_par),
      .rx_data_par         (rx_data_par),
      .ecfg_rx_datain      (ecfg_rx_datain),
      .rxo_wr_wait         (rxo_wr_wait),
      .rxo_rd_wait         (rxo_rd_wait)
   );

   erx_protocol u_protocol (
      .rx_lclk_div4 (rx_lclk_div4),
      .rxreset      (rxreset),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .pkt_valid    (pkt_valid),
      .pkt          (pkt)
   );

   erx_disty u_disty (
      .rx_lclk_div4  (rx_lclk_div4),
      .rxreset       (rxreset),
      .pkt_valid     (pkt_valid),
      .pkt           (pkt),
      .wr_push       (wr_push),
      .rd_push       (rd_push),
      .push_packet   (push_packet),
      .bad_cmd_count (bad_cmd_count)
   );

   // write transactions
   erx_fifo u_wr_queue (
      .rx_lclk_div4  (rx_lclk_div4),
      .rxreset       (rxreset),
      .push          (wr_push),
      .push_packet   (push_packet),
      .credit_return (wr_credit_return),
      .queue_wait    (wr_wait),
      .access        (wr_access),
      .packet        (wr_packet)
   );

   // read requests
   erx_fifo u_rd_queue (
      .rx_lclk_div4  (rx_lclk_div4),
      .rxreset       (rxreset),
      .push          (rd_push),
      .push_packet   (push_packet),
      .credit_return (rd_credit_return),
      .queue_wait    (rd_wait),
      .access        (rd_access),
      .packet        (rd_packet)
   );

endmodule

// ==== testbench/erx_tb.sv ====
module erx_tb
   import elink_pkg::*, erx_cfg_pkg::*;
();

   localparam int TABLE_LEN       = 10;
   localparam int WATCHDOG_CYCLES = TABLE_LEN * 50 + 2000;
   localparam int DRAIN_LIMIT     = 400;   // cycles allowed for queues to empty

   // one table row
   typedef struct packed {
      logic [3:0]  cmd;        // raw code that may be illegal
      logic [1:0]  datamode;
      logic [2:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;
      logic        to_rd;      // 1 = read queue
      logic        legal;      // 0 = expect drop
   } stim_t;

   logic          rx_lclk_div4;
   logic          rxreset;
   logic [7:0]    rx_frame_des;
   logic [63:0]   rx_data_des;
   logic          ecfg_rx_enable;
   logic          ecfg_rx_gpio_enable;
   logic [1:0]    ecfg_dataout;
   logic          wr_credit_return = 1'b0;   // driven by consumer model
   logic          rd_credit_return = 1'b0;
   logic          rxo_wr_wait;
   logic          rxo_rd_wait;
   logic [8:0]    ecfg_rx_datain;
   logic          wr_access;
   emesh_packet_t wr_packet;
   logic          rd_access;
   emesh_packet_t rd_packet;
   logic [7:0]    bad_cmd_count;

   stim_t         stim_table [TABLE_LEN];
   emesh_packet_t wr_model [$];   // expected order per queue
   emesh_packet_t rd_model [$];
   int            bad_expected = 0;
   int            wr_seen = 0;      // accesses observed
   int            wr_owed = 0;      // credits the consumer still holds
   int            rd_owed = 0;
   logic          credit_hold = 1'b0;
   integer        seed = 32'ha44a;
   int            checks = 0;
   int            errors = 0;

   erx_top dut (.*);

   initial
   begin
      rx_lclk_div4 = 1'b0;
      forever #5 rx_lclk_div4 = ~rx_lclk_div4;
   end

   //############################
   // packet encoding
   //############################
   function automatic logic [63:0] head_word(input stim_t e);
      return {e.data[23:16], e.data[31:24],                    // bytes 7,6
              e.dstaddr[7:0], e.dstaddr[15:8],
              e.dstaddr[23:16], e.dstaddr[31:24],              // byte 2 is msb
              {5'b0, e.ctrlmode}, {2'b0, e.datamode, e.cmd}};
   endfunction

   function automatic logic [63:0] tail_word(input stim_t e);
      return {16'hc3c3,                                         // ignored bytes
              e.srcaddr[7:0], e.srcaddr[15:8],
              e.srcaddr[23:16], e.srcaddr[31:24],
              e.data[7:0], e.data[15:8]};
   endfunction

   function automatic emesh_packet_t expected_packet(input stim_t e);
      emesh_packet_t p;
      p.cmd      = emesh_cmd_t'(e.cmd);
      p.datamode = e.datamode;
      p.ctrlmode = e.ctrlmode;
      p.dstaddr  = e.dstaddr;
      p.data     = e.data;
      p.srcaddr  = e.srcaddr;
      return p;
   endfunction

   //############################
   // compare tasks
   //############################
   task automatic check_packet(input emesh_packet_t got, input emesh_packet_t exp,
                               input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t: %s packet %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input logic [7:0] got, input logic [7:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_pins(input logic wr_got, input logic rd_got, input logic [8:0] din_got,
                             input logic wr_exp, input logic rd_exp, input logic [8:0] din_exp,
                             input string what);
      checks++;
      if (wr_got !== wr_exp || rd_got !== rd_exp || din_got !== din_exp)
      begin
         errors++;
         $display("ERROR %0t: %s wait %b/%b datain %h, expected %b/%b %h", $time, what,
                  wr_got, rd_got, din_got, wr_exp, rd_exp, din_exp);
      end
   endtask

   //############################
   // stimulus tasks
   //############################
   task automatic idle_cycles(input int n);
      int i;
      for (i = 0; i < n; i++)
      begin
         @(posedge rx_lclk_div4);
         rx_frame_des <= 8'h00;
         rx_data_des  <= 64'h0;
      end
   endtask

   // gap word then head and tail word
   // live low when the packet must not come out
   task automatic send_entry(input stim_t e, input logic live);
      @(negedge rx_lclk_div4);
      while (e.to_rd ? rxo_rd_wait : rxo_wr_wait)   // sender honours link wait
         @(negedge rx_lclk_div4);
      if (live && e.legal && e.to_rd)
         rd_model.push_back(expected_packet(e));
      else if (live && e.legal)
         wr_model.push_back(expected_packet(e));
      else if (live)
         bad_expected++;
      @(posedge rx_lclk_div4);
      rx_frame_des <= 8'h00;
      rx_data_des  <= 64'h0;
      @(posedge rx_lclk_div4);
      rx_frame_des <= FRAME_ON;
      rx_data_des  <= head_word(e);
      @(posedge rx_lclk_div4);
      rx_data_des  <= tail_word(e);
   endtask

   // steady pin pattern for gpio sampling with frame bit 0 set and byte 0 at 5a
   task automatic drive_gpio(input logic [1:0] dataout);
      @(posedge rx_lclk_div4);
      ecfg_dataout <= dataout;
      rx_frame_des <= 8'h01;
      rx_data_des  <= 64'h5a;
      repeat (4) @(posedge rx_lclk_div4);
      @(negedge rx_lclk_div4);
   endtask

   task automatic drain_queues(input string what);
      int n;
      n = 0;
      idle_cycles(1);
      @(negedge rx_lclk_div4);
      while ((wr_model.size() != 0 || rd_model.size() != 0 || wr_owed != 0 || rd_owed != 0)
             && n < DRAIN_LIMIT)
      begin
         @(negedge rx_lclk_div4);
         n++;
      end
      if (n >= DRAIN_LIMIT)
      begin
         errors++;
         $display("queues did not drain after %s, %0d write and %0d read packets missing",
                  what, wr_model.size(), rd_model.size());
      end
      idle_cycles(3);   // last credit return lands
      @(negedge rx_lclk_div4);
   endtask

   //############################
   // consumer and monitor
   //############################
   always @(posedge rx_lclk_div4)
   begin
      if (wr_access)
         wr_owed = wr_owed + 1;
      if (rd_access)
         rd_owed = rd_owed + 1;
      wr_credit_return <= 1'b0;
      rd_credit_return <= 1'b0;
      if (!credit_hold && wr_owed > 0 && ($random(seed) & 3) == 0)
      begin
         wr_credit_return <= 1'b1;   // one credit back
         wr_owed = wr_owed - 1;
      end
      if (!credit_hold && rd_owed > 0 && ($random(seed) & 3) == 0)
      begin
         rd_credit_return <= 1'b1;
         rd_owed = rd_owed - 1;
      end
   end

   always @(posedge rx_lclk_div4)
   begin
      if (wr_access)
      begin
         wr_seen = wr_seen + 1;
         if (wr_model.size() == 0)
         begin
            errors++;
            $display("ERROR %0t: write access with no packet expected", $time);
         end
         else
            check_packet(wr_packet, wr_model.pop_front(), "write queue");
      end
      if (rd_access)
      begin
         if (rd_model.size() == 0)
         begin
            errors++;
            $display("ERROR %0t: read access with no packet expected", $time);
         end
         else
            check_packet(rd_packet, rd_model.pop_front(), "read queue");
      end
   end

   //############################
   // test sequence
   //############################
   initial
   begin
      stim_t e;
      int    i;
      int    n;
      int    base;
      rxreset             = 1'b1;
      rx_frame_des        = 8'h00;
      rx_data_des         = 64'h0;
      ecfg_rx_enable      = 1'b1;
      ecfg_rx_gpio_enable = 1'b0;
      ecfg_dataout        = 2'b00;
      //               cmd    dm    cm    dstaddr        data           srcaddr      rd    ok
      stim_table[0] = '{4'h0, 2'd2, 3'd0, 32'h8000_0010, 32'hdead_beef, 32'h0000_0000, 1'b0, 1'b1};
      stim_table[1] = '{4'h1, 2'd2, 3'd1, 32'h8100_0020, 32'h0000_0000, 32'h8200_0040, 1'b1, 1'b1};
      stim_table[2] = '{4'h2, 2'd3, 3'd2, 32'h1234_5678, 32'h0bad_cafe, 32'h9abc_def0, 1'b0, 1'b1};
      stim_table[3] = '{4'h7, 2'd1, 3'd3, 32'h0000_0100, 32'h1111_2222, 32'h3333_4444, 1'b0, 1'b0};
      stim_table[4] = '{4'h1, 2'd0, 3'd7, 32'hfeed_0004, 32'h0000_0000, 32'h8300_0080, 1'b1, 1'b1};
      stim_table[5] = '{4'h0, 2'd1, 3'd4, 32'hffff_fffc, 32'h0000_ffff, 32'h0000_0000, 1'b0, 1'b1};
      stim_table[6] = '{4'hf, 2'd3, 3'd5, 32'h5555_aaaa, 32'hffff_ffff, 32'haaaa_5555, 1'b0, 1'b0};
      stim_table[7] = '{4'h1, 2'd3, 3'd6, 32'h0000_0008, 32'h0000_0000, 32'h8400_00c0, 1'b1, 1'b1};
      stim_table[8] = '{4'h0, 2'd0, 3'd0, 32'h2000_0001, 32'ha5a5_5a5a, 32'h0000_0000, 1'b0, 1'b1};
      stim_table[9] = '{4'h2, 2'd2, 3'd1, 32'h7fff_fff0, 32'h0123_4567, 32'h89ab_cdef, 1'b0, 1'b1};
      repeat (2) @(posedge rx_lclk_div4);
      rxreset <= 1'b0;
      idle_cycles(SYNC_STAGES + 2);   // enable sync fills
      @(negedge rx_lclk_div4);
      check_pins(rxo_wr_wait, rxo_rd_wait, ecfg_rx_datain, 1'b0, 1'b0, 9'h000, "after reset");
      check_count({6'b0, wr_access, rd_access}, 8'h00, "access after reset");

      // legal and illegal packets from the table
      for (i = 0; i < TABLE_LEN; i++)
         send_entry(stim_table[i], 1'b1);
      drain_queues("table");

      // rx disabled so the frame must be masked
      @(posedge rx_lclk_div4);
      ecfg_rx_enable <= 1'b0;
      send_entry(stim_table[1], 1'b0);
      idle_cycles(8);
      @(posedge rx_lclk_div4);
      ecfg_rx_enable <= 1'b1;
      idle_cycles(SYNC_STAGES + 2);

      // in gpio mode the pins follow ecfg_dataout and datain samples raw input
      @(posedge rx_lclk_div4);
      ecfg_rx_gpio_enable <= 1'b1;
      drive_gpio(2'b10);
      check_pins(rxo_wr_wait, rxo_rd_wait, ecfg_rx_datain, 1'b1, 1'b0, 9'h15a, "gpio 10");
      drive_gpio(2'b01);
      check_pins(rxo_wr_wait, rxo_rd_wait, ecfg_rx_datain, 1'b0, 1'b1, 9'h15a, "gpio 01");
      send_entry(stim_table[0], 1'b0);
      idle_cycles(8);
      @(posedge rx_lclk_div4);
      ecfg_rx_gpio_enable <= 1'b0;
      ecfg_dataout        <= 2'b11;   // pins must now come from the idle queues
      idle_cycles(SYNC_STAGES + 2);
      @(negedge rx_lclk_div4);
      check_pins(rxo_wr_wait, rxo_rd_wait, ecfg_rx_datain, 1'b0, 1'b0, 9'h000, "gpio off");

      // with credits withheld the write queue fills up to its wait level
      drain_queues("gpio test");
      base = wr_seen;
      @(posedge rx_lclk_div4);
      credit_hold <= 1'b1;
      for (i = 0; i < CREDIT_INIT + WAIT_LEVEL; i++)
      begin
         e = '{4'h0, 2'd2, 3'd0, 32'h4000_0000 + 32'(i * 4), {16'hc0de, 16'(i)}, 32'h0,
               1'b0, 1'b1};
         send_entry(e, 1'b1);
      end
      idle_cycles(3);
      n = 0;
      @(negedge rx_lclk_div4);
      while (!rxo_wr_wait && n < 50)
      begin
         @(negedge rx_lclk_div4);
         n++;
      end
      check_count(8'(wr_seen - base), 8'(CREDIT_INIT), "accesses with credits held");
      check_pins(rxo_wr_wait, rxo_rd_wait, ecfg_rx_datain, 1'b1, 1'b0, 9'h000, "queue at level");
      @(posedge rx_lclk_div4);
      credit_hold <= 1'b0;
      drain_queues("credit release");
      check_pins(rxo_wr_wait, rxo_rd_wait, ecfg_rx_datain, 1'b0, 1'b0, 9'h000, "after release");

      check_count(bad_cmd_count, 8'(bad_expected), "bad_cmd_count");
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // watchdog scaled by table length
   initial
   begin
      #(WATCHDOG_CYCLES * 10);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== project.f ====
design/elink_pkg.sv
design/erx_cfg_pkg.sv
design/erx_io.sv
design/erx_protocol.sv
design/erx_disty.sv
design/erx_fifo.sv
design/erx_top.sv
testbench/erx_tb.sv

// ==== Bender.yml ====
package:
  name: erx

sources:
  # packages first
  - design/elink_pkg.sv
  - design/erx_cfg_pkg.sv
  - design/erx_io.sv
  - design/erx_protocol.sv
  - design/erx_disty.sv
  - design/erx_fifo.sv
  - design/erx_top.sv
  - target: simulation
    files:
      - testbench/erx_tb.sv
